// ==== all.f ====
design/lcd_pkg.sv
design/lcd_cycle_if.sv
design/lcd_delay_timer.sv
design/lcd_bus_cycle.sv
design/lcd_init_seq.sv
design/lcd_ctrl.sv
design/lcd16x2_top.sv
verif/lcd16x2_tb.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = lcd16x2_tb
FILELIST = all.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	-./$(BUILD)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "Test passed" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== verif/lcd16x2_tb.sv ====
`timescale 1ns/1ps

module lcd16x2_tb;

  localparam int CLK_PERIOD = 40;
  localparam int EN_WIDTH   = 8;          // 40 ns setup plus 250 ns pulse, 1 + 7 cycles
  localparam int INIT_BYTES = 8;          // Command bytes on the bus per init
  localparam int NUM_WRITES = 10;
  localparam int NOP_CYCLES = 2000;
  // Each init is about 2.77M cycles, two of them plus writes and the NOP window
  localparam int MAX_CYCLES = 7_000_000;

  logic               clk_i = 1'b0;
  logic               flag_rst;
  lcd_pkg::lcd_data_t data_i;
  lcd_pkg::lcd_op_e   ops_i;
  logic               enb_i;
  logic               rdy_o;
  logic               lcd_rs_o;
  logic               lcd_e_o;
  lcd_pkg::lcd_data_t lcd_data_o;

  logic               rs_q[$];      // RS at each enable fall
  lcd_pkg::lcd_data_t data_q[$];    // Data at each enable fall
  int                 width_q[$];   // Enable widths over the whole run
  time                e_rise_t;
  logic               in_pulse    = 1'b0;
  int                 cycle_count = 0;
  integer             seed        = 32'h0edc68fb;

  lcd16x2_top u_lcd16x2_top (
    .clk_i      (clk_i),
    .flag_rst   (flag_rst),
    .data_i     (data_i),
    .ops_i      (ops_i),
    .enb_i      (enb_i),
    .rdy_o      (rdy_o),
    .lcd_rs_o   (lcd_rs_o),
    .lcd_e_o    (lcd_e_o),
    .lcd_data_o (lcd_data_o)
  );

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  ////////////////////////////////////////
  // Bus monitor and watchdog
  ////////////////////////////////////////
  always @(posedge lcd_e_o) begin
    if (lcd_e_o === 1'b1) begin  // Only a real rise to high
      e_rise_t = $time;
      in_pulse = 1'b1;
    end
  end

  // LCD latches on the falling edge
  always @(negedge lcd_e_o) begin
    if (in_pulse) begin
      rs_q.push_back(lcd_rs_o);
      data_q.push_back(lcd_data_o);
      width_q.push_back(int'(($time - e_rise_t) / CLK_PERIOD));
      in_pulse = 1'b0;
    end
  end

  always @(posedge clk_i) begin
    cycle_count++;
    if (cycle_count >= MAX_CYCLES) begin
      stop_with_failure("Timeout: the run went past its cycle limit");
    end
  end

  ////////////////////////////////////////
  // Checking helpers
  ////////////////////////////////////////
  task automatic stop_with_failure(string what);
    $display("%s", what);
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic compare_data(string name, lcd_pkg::lcd_data_t got, lcd_pkg::lcd_data_t exp);
    if (got !== exp) begin
      stop_with_failure($sformatf("Fail %s got %h expected %h", name, got, exp));
    end
  endtask

  task automatic compare_bit(string name, logic got, logic exp);
    if (got !== exp) begin
      stop_with_failure($sformatf("Fail %s got %h expected %h", name, got, exp));
    end
  endtask

  task automatic compare_count(string name, int got, int exp);
    if (got != exp) begin
      stop_with_failure($sformatf("Fail %s got %h expected %h", name, got, exp));
    end
  endtask

  task automatic next_cycle();
    @(posedge clk_i);
    #2;
  endtask

  task automatic clear_capture();
    rs_q.delete();
    data_q.delete();
  endtask

  // One host request, returns just after the accepting edge
  task automatic pulse_op(lcd_pkg::lcd_op_e op, lcd_pkg::lcd_data_t b);
    enb_i  = 1'b1;
    ops_i  = op;
    data_i = b;
    next_cycle();
    enb_i  = 1'b0;
    ops_i  = lcd_pkg::OP_NOP;
  endtask

  task automatic wait_ready();
    while (rdy_o !== 1'b1) begin
      next_cycle();
    end
  endtask

  // Command bytes of the power-up sequence, in bus order
  function automatic lcd_pkg::lcd_data_t init_byte(int idx);
    case (idx)
      0, 1, 2: return lcd_pkg::CMD_WAKE;
      3:       return lcd_pkg::CMD_SETUP;
      4:       return lcd_pkg::CMD_DISP_OFF;
      5:       return lcd_pkg::CMD_CLEAR;
      6:       return lcd_pkg::CMD_ENTRY_N;
      default: return lcd_pkg::CMD_DISP_ON;
    endcase
  endfunction

  task automatic check_init_sequence();
    compare_count("init entry count", data_q.size(), INIT_BYTES);
    for (int i = 0; i < INIT_BYTES; i++) begin
      compare_bit($sformatf("lcd_rs_o entry %0d", i), rs_q[i], 1'b0);
      compare_data($sformatf("lcd_data_o entry %0d", i), data_q[i], init_byte(i));
    end
  endtask

  task automatic write_char(lcd_pkg::lcd_data_t b);
    clear_capture();
    pulse_op(lcd_pkg::OP_WRITE, b);
    compare_bit("rdy_o after write accept", rdy_o, 1'b0);
    wait_ready();
    compare_count("write entry count", data_q.size(), 1);
    compare_bit("lcd_rs_o", rs_q[0], 1'b1);
    compare_data("lcd_data_o", data_q[0], b);
  endtask

  ////////////////////////////////////////
  // Tests
  ////////////////////////////////////////
  task automatic test_reset();
    flag_rst = 1'b1;
    repeat (4) begin
      next_cycle();
      compare_bit("rdy_o in reset", rdy_o, 1'b0);
      compare_bit("lcd_e_o in reset", lcd_e_o, 1'b0);
      compare_bit("lcd_rs_o in reset", lcd_rs_o, 1'b0);
      compare_data("lcd_data_o in reset", lcd_data_o, 8'h00);
    end
    flag_rst = 1'b0;
    next_cycle();  // Init starts here
    compare_bit("rdy_o after reset", rdy_o, 1'b0);
    compare_bit("lcd_e_o after reset", lcd_e_o, 1'b0);
  endtask

  task automatic test_ignored_during_init();
    repeat (100) next_cycle();
    pulse_op(lcd_pkg::OP_WRITE, 8'hA5);  // Power-up wait
    compare_bit("rdy_o during init", rdy_o, 1'b0);
    while (data_q.size() < 3) begin
      next_cycle();
    end
    pulse_op(lcd_pkg::OP_WRITE, 8'h5A);  // Commands already on the bus
    compare_bit("rdy_o during init", rdy_o, 1'b0);
  endtask

  task automatic test_init_done();
    wait_ready();
    check_init_sequence();
  endtask

  task automatic test_char_writes();
    for (int n = 0; n < NUM_WRITES; n++) begin
      write_char(lcd_pkg::lcd_data_t'($random(seed)));
    end
  endtask

  task automatic test_nop();
    clear_capture();
    enb_i = 1'b1;
    ops_i = lcd_pkg::OP_NOP;
    for (int i = 0; i < NOP_CYCLES; i++) begin
      if (i == NOP_CYCLES / 2) begin
        ops_i = lcd_pkg::lcd_op_e'(2'd3);  // Unused code
      end
      next_cycle();
      compare_bit("rdy_o during NOP", rdy_o, 1'b1);
      compare_bit("lcd_e_o during NOP", lcd_e_o, 1'b0);
    end
    enb_i = 1'b0;
    ops_i = lcd_pkg::OP_NOP;
    compare_count("entries after NOP", data_q.size(), 0);
  endtask

  task automatic test_reinit();
    clear_capture();
    pulse_op(lcd_pkg::OP_REINIT, 8'h00);
    compare_bit("rdy_o after reinit accept", rdy_o, 1'b0);
    wait_ready();
    check_init_sequence();
    write_char(lcd_pkg::lcd_data_t'($random(seed)));
  endtask

  task automatic test_enable_width();
    compare_count("enable pulse count", width_q.size(), 2 * INIT_BYTES + NUM_WRITES + 1);
    foreach (width_q[i]) begin
      compare_count($sformatf("lcd_e_o high cycles %0d", i), width_q[i], EN_WIDTH);
    end
  endtask

  initial begin
    flag_rst = 1'b1;
    enb_i    = 1'b0;
    ops_i    = lcd_pkg::OP_NOP;
    data_i   = '0;
    test_reset();
    test_ignored_during_init();
    test_init_done();
    test_char_writes();
    test_nop();
    test_reinit();
    test_enable_width();
    $display("Test passed");
    $finish;
  end

endmodule

// ==== design/lcd16x2_top.sv ====
`timescale 1ns/1ps

module lcd16x2_top (
  input  logic               clk_i,
  input  logic               flag_rst,
  input  lcd_pkg::lcd_data_t data_i,
  input  lcd_pkg::lcd_op_e   ops_i,
  input  logic               enb_i,
  output logic               rdy_o,
  output logic               lcd_rs_o,
  output logic               lcd_e_o,
  output lcd_pkg::lcd_data_t lcd_data_o
);

  logic               seq_restart;
  logic               seq_advance;
  logic               seq_rs;
  lcd_pkg::lcd_data_t seq_data;
  logic               seq_pulse;
  lcd_pkg::lcd_wait_e seq_wait_sel;
  logic               seq_last;

  lcd_cycle_if u_cyc ();

  lcd_ctrl u_ctrl (
    .clk_i (clk_i), .flag_rst (flag_rst), .data_i (data_i), .ops_i (ops_i),
    .enb_i (enb_i), .rdy_o (rdy_o), .cyc (u_cyc.master),
    .seq_restart_o (seq_restart), .seq_advance_o (seq_advance),
    .seq_rs_i (seq_rs), .seq_data_i (seq_data), .seq_pulse_i (seq_pulse),
    .seq_wait_sel_i (seq_wait_sel), .seq_last_i (seq_last)
  );

  lcd_init_seq u_init_seq (
    .clk_i (clk_i), .flag_rst (flag_rst), .restart_i (seq_restart),
    .advance_i (seq_advance), .rs_o (seq_rs), .data_o (seq_data),
    .pulse_o (seq_pulse), .wait_sel_o (seq_wait_sel), .last_o (seq_last)
  );

  lcd_bus_cycle u_bus_cycle (
    .clk_i (clk_i), .flag_rst (flag_rst), .cyc (u_cyc.slave),
    .lcd_rs_o (lcd_rs_o), .lcd_e_o (lcd_e_o), .lcd_data_o (lcd_data_o)
  );

endmodule

// ==== design/lcd_ctrl.sv ====
`timescale 1ns/1ps

module lcd_ctrl (
  input  logic               clk_i,
  input  logic               flag_rst,
  input  lcd_pkg::lcd_data_t data_i,
  input  lcd_pkg::lcd_op_e   ops_i,
  input  logic               enb_i,
  output logic               rdy_o,
  lcd_cycle_if.master        cyc,
  output logic               seq_restart_o,
  output logic               seq_advance_o,
  input  logic               seq_rs_i,
  input  lcd_pkg::lcd_data_t seq_data_i,
  input  logic               seq_pulse_i,
  input  lcd_pkg::lcd_wait_e seq_wait_sel_i,
  input  logic               seq_last_i
);

  typedef enum logic [1:0] {
    M_INIT,
    M_IDLE,
    M_WRITE
  } mode_e;

  mode_e              mode;
  lcd_pkg::lcd_data_t wr_data;

  assign rdy_o = (mode == M_IDLE);

  ////////////////////////////////////////
  // Host decode and sequencer control
  ////////////////////////////////////////
  assign seq_restart_o = rdy_o && enb_i && (ops_i == lcd_pkg::OP_REINIT);
  assign seq_advance_o = (mode == M_INIT) && cyc.done && !seq_last_i;

  always_ff @(posedge clk_i) begin
    if (flag_rst) begin
      mode <= M_INIT;
    end else begin
      case (mode)
        M_INIT:  if (cyc.done && seq_last_i) mode <= M_IDLE;
        M_IDLE:  if (enb_i) begin
          case (ops_i)
            lcd_pkg::OP_WRITE:  mode <= M_WRITE;
            lcd_pkg::OP_REINIT: mode <= M_INIT;
            default:            mode <= M_IDLE;  // NOP and code 3
          endcase
        end
        M_WRITE: if (cyc.done) mode <= M_IDLE;
        default: mode <= M_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (rdy_o && enb_i && ops_i == lcd_pkg::OP_WRITE) begin
      wr_data <= data_i;
    end
  end

  ////////////////////////////////////////
  // Transfer request
  ////////////////////////////////////////
  assign cyc.start    = (mode != M_IDLE) && !cyc.busy;  // Busy covers the transfer in flight
  assign cyc.rs       = (mode == M_WRITE) ? 1'b1 : seq_rs_i;
  assign cyc.data     = (mode == M_WRITE) ? wr_data : seq_data_i;
  assign cyc.pulse    = (mode == M_WRITE) ? 1'b1 : seq_pulse_i;
  assign cyc.wait_sel = (mode == M_WRITE) ? lcd_pkg::W_WRITE : seq_wait_sel_i;

  // Host only sees ready once the bus engine is finished
  a_rdy_not_busy: assert property (
    @(posedge clk_i) disable iff (flag_rst)
    !(rdy_o && cyc.busy)
  );

endmodule

// ==== design/lcd_init_seq.sv ====
`timescale 1ns/1ps

module lcd_init_seq (
  input  logic               clk_i,
  input  logic               flag_rst,
  input  logic               restart_i,
  input  logic               advance_i,
  output logic               rs_o,
  output lcd_pkg::lcd_data_t data_o,
  output logic               pulse_o,
  output lcd_pkg::lcd_wait_e wait_sel_o,
  output logic               last_o
);

  typedef logic [$clog2(lcd_pkg::INIT_STEPS)-1:0] step_t;

  step_t step;

  always_ff @(posedge clk_i) begin
    if (flag_rst || restart_i) begin
      step <= '0;
    end else if (advance_i && !last_o) begin
      step <= step + 1'b1;
    end
  end

  assign last_o = (step == step_t'(lcd_pkg::INIT_STEPS - 1));

  ////////////////////////////////////////
  // Power-up command table
  ////////////////////////////////////////
  always_comb begin
    rs_o       = 1'b0;  // Every entry is a command
    data_o     = '0;
    pulse_o    = 1'b1;
    wait_sel_o = lcd_pkg::W_60US;
    case (step)
      0: begin
        pulse_o    = 1'b0;  // Let the supply settle, no bus activity
        wait_sel_o = lcd_pkg::W_POWERUP;
      end
      1: begin
        data_o     = lcd_pkg::CMD_WAKE;
        wait_sel_o = lcd_pkg::W_LONG;
      end
      2, 3: begin
        data_o     = lcd_pkg::CMD_WAKE;
        wait_sel_o = lcd_pkg::W_100US;
      end
      4: begin
        data_o     = lcd_pkg::CMD_SETUP;
        wait_sel_o = lcd_pkg::W_100US;
      end
      5: data_o = lcd_pkg::CMD_DISP_OFF;
      6: begin
        data_o     = lcd_pkg::CMD_CLEAR;
        wait_sel_o = lcd_pkg::W_LONG;  // Clear is the slow one
      end
      7: data_o = lcd_pkg::CMD_ENTRY_N;
      8: data_o = lcd_pkg::CMD_DISP_ON;
      default: ;
    endcase
  end

endmodule

// ==== design/lcd_bus_cycle.sv ====
`timescale 1ns/1ps

module lcd_bus_cycle (
  input  logic               clk_i,
  input  logic               flag_rst,
  lcd_cycle_if.slave         cyc,
  output logic               lcd_rs_o,
  output logic               lcd_e_o,
  output lcd_pkg::lcd_data_t lcd_data_o
);

  typedef enum logic [2:0] {
    P_IDLE,
    P_SETUP,
    P_PULSE,
    P_HOLD,
    P_WAIT
  } phase_e;

  phase_e              phase;
  lcd_pkg::lcd_wait_e  wait_q;      // Wait chosen at start
  logic                tmr_load;
  lcd_pkg::lcd_delay_t tmr_cycles;
  logic                tmr_done;

  function automatic lcd_pkg::lcd_delay_t wait_cycles(lcd_pkg::lcd_wait_e sel);
    case (sel)
      lcd_pkg::W_POWERUP: return lcd_pkg::C_WAIT_POWERUP;
      lcd_pkg::W_LONG:    return lcd_pkg::C_WAIT_LONG;
      lcd_pkg::W_100US:   return lcd_pkg::C_WAIT_100US;
      lcd_pkg::W_60US:    return lcd_pkg::C_WAIT_60US;
      lcd_pkg::W_WRITE:   return lcd_pkg::C_WAIT_WRITE;
      default:            return lcd_pkg::C_WAIT_LONG;  // Safe side for bad codes
    endcase
  endfunction

  ////////////////////////////////////////
  // Timer loads for each phase
  ////////////////////////////////////////
  always_comb begin
    tmr_load   = 1'b0;
    tmr_cycles = lcd_pkg::C_SETUP;
    case (phase)
      P_IDLE: begin
        tmr_load   = cyc.start;
        tmr_cycles = cyc.pulse ? lcd_pkg::C_SETUP : wait_cycles(cyc.wait_sel);
      end
      P_SETUP: begin
        tmr_load   = tmr_done;
        tmr_cycles = lcd_pkg::C_PULSE;
      end
      P_PULSE: begin
        tmr_load   = tmr_done;
        tmr_cycles = lcd_pkg::C_HOLD;
      end
      P_HOLD: begin
        tmr_load   = tmr_done;
        tmr_cycles = wait_cycles(wait_q);
      end
      default: ;  // Wait phase only runs out
    endcase
  end

  lcd_delay_timer u_timer (
    .clk_i    (clk_i),
    .flag_rst (flag_rst),
    .load_i   (tmr_load),
    .cycles_i (tmr_cycles),
    .done_o   (tmr_done)
  );

  ////////////////////////////////////////
  // Phase machine and bus outputs
  ////////////////////////////////////////
  always_ff @(posedge clk_i) begin
    if (flag_rst) begin
      phase      <= P_IDLE;
      lcd_e_o    <= 1'b0;
      lcd_rs_o   <= 1'b0;
      lcd_data_o <= '0;
    end else begin
      case (phase)
        P_IDLE: if (cyc.start) begin
          lcd_rs_o   <= cyc.rs;
          lcd_data_o <= cyc.data;
          lcd_e_o    <= cyc.pulse;          // Enable rises with valid RS and data
          phase      <= cyc.pulse ? P_SETUP : P_WAIT;
        end
        P_SETUP: if (tmr_done) phase <= P_PULSE;
        P_PULSE: if (tmr_done) begin
          lcd_e_o <= 1'b0;                  // LCD latches on this edge
          phase   <= P_HOLD;
        end
        P_HOLD:  if (tmr_done) phase <= P_WAIT;
        P_WAIT:  if (tmr_done) phase <= P_IDLE;
        default: phase <= P_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (phase == P_IDLE && cyc.start) begin
      wait_q <= cyc.wait_sel;
    end
  end

  assign cyc.busy = (phase != P_IDLE);
  assign cyc.done = (phase == P_WAIT) && tmr_done;

  a_no_start_busy: assert property (
    @(posedge clk_i) disable iff (flag_rst)
    cyc.start |-> !cyc.busy
  );

  // Bus must not move while the LCD may sample it
  a_bus_stable: assert property (
    @(posedge clk_i) disable iff (flag_rst)
    (lcd_e_o && phase == P_PULSE) |-> ($stable(lcd_data_o) && $stable(lcd_rs_o))
  );

endmodule

// ==== design/lcd_delay_timer.sv ====
`timescale 1ns/1ps

module lcd_delay_timer (
  input  logic                clk_i,
  input  logic                flag_rst,
  input  logic                load_i,
  input  lcd_pkg::lcd_delay_t cycles_i,
  output logic                done_o
);

  lcd_pkg::lcd_delay_t cnt;
  logic                active;

  // Last cycle of the loaded count
  assign done_o = active && (cnt == lcd_pkg::lcd_delay_t'(1));

  always_ff @(posedge clk_i) begin
    if (flag_rst) begin
      cnt    <= '0;
      active <= 1'b0;
    end else if (load_i) begin
      cnt    <= cycles_i;  // Reload may chain on the expiring cycle
      active <= 1'b1;
    end else if (active) begin
      cnt <= cnt - 1'b1;
      if (done_o) begin
        active <= 1'b0;
      end
    end
  end

  // A new delay only starts once the previous one runs out
  a_load_when_free: assert property (
    @(posedge clk_i) disable iff (flag_rst)
    load_i |-> (!active || done_o)
  );

endmodule

// ==== design/lcd_cycle_if.sv ====
`timescale 1ns/1ps

interface lcd_cycle_if;

  // Request side
  logic                  start;     // One-cycle pulse, only while busy is low
  logic                  rs;
  lcd_pkg::lcd_data_t    data;
  logic                  pulse;     // Low for a wait-only transfer
  lcd_pkg::lcd_wait_e    wait_sel;

  // Completion side
  logic                  busy;
  logic                  done;      // One-cycle pulse at the end of the wait

  modport master (
    output start, rs, data, pulse, wait_sel,
    input  busy, done
  );

  modport slave (
    input  start, rs, data, pulse, wait_sel,
    output busy, done
  );

endinterface

// ==== design/lcd_pkg.sv ====
package lcd_pkg;

  ////////////////////////////////////////
  // Clock and delay counts
  ////////////////////////////////////////
  localparam int CLK_FREQ_HZ = 25_000_000;  // 40 ns period
  localparam int DELAY_W     = 22;          // Power-up count needs more than 20 bits

  typedef logic [DELAY_W-1:0] lcd_delay_t;
  typedef logic [7:0]         lcd_data_t;

  // Nanoseconds to clock cycles, rounded up so no delay runs short
  function automatic lcd_delay_t ns_to_cycles(longint t_ns);
    longint prod;
    prod = t_ns * CLK_FREQ_HZ;
    return lcd_delay_t'((prod + 999_999_999) / 1_000_000_000);
  endfunction

  localparam lcd_delay_t C_SETUP        = ns_to_cycles(40);           // 1
  localparam lcd_delay_t C_PULSE        = ns_to_cycles(250);          // 7
  localparam lcd_delay_t C_HOLD         = ns_to_cycles(250);          // 7
  localparam lcd_delay_t C_WAIT_POWERUP = ns_to_cycles(100_060_000);  // 100 ms plus 60 us
  localparam lcd_delay_t C_WAIT_LONG    = ns_to_cycles(5_000_000);
  localparam lcd_delay_t C_WAIT_100US   = ns_to_cycles(100_000);
  localparam lcd_delay_t C_WAIT_60US    = ns_to_cycles(60_000);
  localparam lcd_delay_t C_WAIT_WRITE   = ns_to_cycles(42_000);

  ////////////////////////////////////////
  // Command bytes
  ////////////////////////////////////////
  localparam lcd_data_t CMD_WAKE     = 8'h30;  // Function set, wake-up form
  localparam lcd_data_t CMD_SETUP    = 8'h38;  // 8-bit, 2 lines, 5x8 font
  localparam lcd_data_t CMD_DISP_OFF = 8'h08;
  localparam lcd_data_t CMD_CLEAR    = 8'h01;
  localparam lcd_data_t CMD_ENTRY_N  = 8'h06;  // Increment, no display shift
  localparam lcd_data_t CMD_DISP_ON  = 8'h0C;  // Cursor and blink off

  ////////////////////////////////////////
  // Shared enumerations
  ////////////////////////////////////////

  // Wait that follows a transfer
  typedef enum logic [2:0] {
    W_POWERUP,
    W_LONG,
    W_100US,
    W_60US,
    W_WRITE
  } lcd_wait_e;

  // Host operation, code 3 behaves as no operation
  typedef enum logic [1:0] {
    OP_NOP    = 2'd0,
    OP_WRITE  = 2'd1,
    OP_REINIT = 2'd2
  } lcd_op_e;

  localparam int INIT_STEPS = 9;  // Entries in the power-up table

endpackage
